// File: rvCore_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Register and data bus width
`define RV_XLEN 32

// Byte address width of the instruction and data memories
`define RV_ADDR_W 12

// PC loaded while reset is held
`define RV_RESET_PC 0

`endif

// File: rvIsaPkg.sv
`default_nettype none

`include "rvCore_settings.svh"

package rvIsaPkg;

	typedef logic [`RV_XLEN-1:0]   wordT;
	typedef logic [31:0]           instrT;
	typedef logic [4:0]            regIdxT;
	typedef logic [`RV_ADDR_W-1:0] pcT;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opImm    = 7'b0010011,
		opReg    = 7'b0110011,
		opSystem = 7'b1110011
	} opcodeE;

	typedef enum logic [2:0] {
		brEq  = 3'b000,
		brNe  = 3'b001,
		brLt  = 3'b100,
		brGe  = 3'b101,
		brLtu = 3'b110,
		brGeu = 3'b111
	} branchF3E;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd, aluPassB
	} aluOpE;

	typedef enum logic [1:0] {
		memByte = 2'b00,
		memHalf = 2'b01,
		memWord = 2'b10
	} memSizeE;

	// R-type view of an instruction word
	typedef struct packed {
		logic [6:0] funct7;
		regIdxT     rs2;
		regIdxT     rs1;
		logic [2:0] funct3;
		regIdxT     rd;
		opcodeE     opcode;
	} instrFieldsT;

endpackage

`default_nettype wire

// File: rvCorePkg.sv
`default_nettype none

package rvCorePkg;

	typedef struct packed {
		rvIsaPkg::pcT    pc;
		rvIsaPkg::instrT instr;
		logic            valid; // Low in reset and after halt
	} fetchT;

	typedef struct packed {
		rvIsaPkg::pcT     pc;
		rvIsaPkg::wordT   imm;
		rvIsaPkg::aluOpE  aluOp;
		logic             aSelPc;  // Operand A is the PC
		logic             bSelImm; // Operand B is the immediate
		rvIsaPkg::branchF3E brFunct3;
		logic             isBranch;
		logic             isJal;
		logic             isJalr;
		logic             isLoad;
		logic             isStore;
		logic             regWrite;
		logic             isHalt;
		rvIsaPkg::memSizeE memSize;
		logic             loadUnsigned;
		rvIsaPkg::regIdxT rd;
	} decodeT;

	typedef struct packed {
		rvIsaPkg::wordT    aluResult;
		rvIsaPkg::wordT    storeData;
		rvIsaPkg::wordT    linkValue; // PC + 4
		logic              redirect;
		rvIsaPkg::pcT      target;
		logic              isLink;
		logic              isLoad;
		logic              isStore;
		logic              regWrite;
		rvIsaPkg::memSizeE memSize;
		logic              loadUnsigned;
		rvIsaPkg::regIdxT  rd;
	} execT;

endpackage

`default_nettype wire

// File: rvFetch.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvCore_settings.svh"

module rvFetch (
	input  wire                   CLK,
	input  wire                   RSTn,
	input  wire                   isHalt,
	input  wire                   redirect,
	input  wire rvIsaPkg::pcT     target,
	output rvCorePkg::fetchT      fetch,
	output rvIsaPkg::pcT          iMemAddr,
	output logic                  iMemCsn,
	input  wire rvIsaPkg::instrT  iMemDi,
	output logic                  halt,
	output rvIsaPkg::wordT        numInst
);

	import rvIsaPkg::*;

	pcT   pc;
	pcT   nextPc;
	logic started; // Set one edge after reset is released

	assign nextPc = redirect ? target : pc + pcT'(4);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc      <= pcT'(`RV_RESET_PC);
			halt    <= 1'b0;
			numInst <= '0;
			started <= 1'b0;
		end else begin
			started <= 1'b1;
			if (fetch.valid) begin
				pc      <= nextPc;
				numInst <= numInst + wordT'(1);
				if (isHalt)
					halt <= 1'b1; // PC frozen from here on
			end
		end
	end

	always_comb begin
		fetch.pc    = pc;
		fetch.instr = iMemDi;
		fetch.valid = started & ~halt;
	end

	assign iMemAddr = pc;
	assign iMemCsn  = ~fetch.valid;

endmodule

`default_nettype wire

// File: rvDecode.sv
`timescale 1ns/10ps
`default_nettype none

module rvDecode (
	input  wire rvCorePkg::fetchT fetch,
	output rvIsaPkg::regIdxT      rfRa1,
	output rvIsaPkg::regIdxT      rfRa2,
	output rvCorePkg::decodeT     dec
);

	import rvIsaPkg::*;

	instrFieldsT fields;
	instrT       ins;
	wordT        immI, immS, immB, immU, immJ;
	logic        altOp;

	function automatic aluOpE aluFromF3(input logic [2:0] funct3, input logic alt);
		aluOpE op;
		case (funct3)
			3'b000:  op = alt ? aluSub : aluAdd;
			3'b001:  op = aluSll;
			3'b010:  op = aluSlt;
			3'b011:  op = aluSltu;
			3'b100:  op = aluXor;
			3'b101:  op = alt ? aluSra : aluSrl;
			3'b110:  op = aluOr;
			default: op = aluAnd;
		endcase
		return op;
	endfunction

	assign ins    = fetch.instr;
	assign fields = instrFieldsT'(ins);

	assign immI = {{20{ins[31]}}, ins[31:20]};
	assign immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	assign immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
	assign immU = {ins[31:12], 12'b0};
	assign immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

	// Bit 30 selects sub/sra only where it is not part of an immediate
	assign altOp = fields.funct7[5] & (fields.opcode == opReg || fields.funct3 == 3'b101);

	assign rfRa1 = fields.rs1;
	assign rfRa2 = fields.rs2;

	always_comb begin
		dec              = '0;
		dec.pc           = fetch.pc;
		dec.aluOp        = aluAdd;
		dec.brFunct3     = branchF3E'(fields.funct3);
		dec.memSize      = memSizeE'(fields.funct3[1:0]);
		dec.loadUnsigned = fields.funct3[2];
		dec.rd           = fields.rd;
		if (fetch.valid) begin
			case (fields.opcode)
				opLui: begin
					dec.imm = immU; dec.bSelImm = 1'b1;
					dec.aluOp = aluPassB; dec.regWrite = 1'b1;
				end
				opAuipc: begin
					dec.imm = immU; dec.aSelPc = 1'b1;
					dec.bSelImm = 1'b1; dec.regWrite = 1'b1;
				end
				opJal: begin
					dec.imm = immJ; dec.isJal = 1'b1; dec.regWrite = 1'b1;
				end
				opJalr: begin // ALU forms rs1 + imm
					dec.imm = immI; dec.bSelImm = 1'b1;
					dec.isJalr = 1'b1; dec.regWrite = 1'b1;
				end
				opBranch: begin
					dec.imm = immB; dec.isBranch = 1'b1;
				end
				opLoad: begin
					dec.imm = immI; dec.bSelImm = 1'b1;
					dec.isLoad = 1'b1; dec.regWrite = 1'b1;
				end
				opStore: begin
					dec.imm = immS; dec.bSelImm = 1'b1; dec.isStore = 1'b1;
				end
				opImm: begin
					dec.imm = immI; dec.bSelImm = 1'b1; dec.regWrite = 1'b1;
					dec.aluOp = aluFromF3(fields.funct3, altOp);
				end
				opReg: begin
					dec.regWrite = 1'b1;
					dec.aluOp = aluFromF3(fields.funct3, altOp);
				end
				opSystem: dec.isHalt = (fields.funct3 == 3'b000); // ECALL
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rvExecute.sv
`timescale 1ns/10ps
`default_nettype none

module rvExecute (
	input  wire rvCorePkg::decodeT dec,
	input  wire rvIsaPkg::wordT    rfRd1,
	input  wire rvIsaPkg::wordT    rfRd2,
	output rvCorePkg::execT        exe,
	output logic                   redirect,
	output rvIsaPkg::pcT           target
);

	import rvIsaPkg::*;

	wordT       opA, opB, aluRes;
	logic [4:0] shamt;
	logic       condMet;
	pcT         pcRel;

	assign opA   = dec.aSelPc ? wordT'(dec.pc) : rfRd1;
	assign opB   = dec.bSelImm ? dec.imm : rfRd2;
	assign shamt = opB[4:0];

	always_comb begin
		case (dec.aluOp)
			aluAdd:   aluRes = opA + opB;
			aluSub:   aluRes = opA - opB;
			aluSll:   aluRes = opA << shamt;
			aluSlt:   aluRes = wordT'($signed(opA) < $signed(opB));
			aluSltu:  aluRes = wordT'(opA < opB);
			aluXor:   aluRes = opA ^ opB;
			aluSrl:   aluRes = opA >> shamt;
			aluSra:   aluRes = wordT'($signed(opA) >>> shamt);
			aluOr:    aluRes = opA | opB;
			aluAnd:   aluRes = opA & opB;
			aluPassB: aluRes = opB; // LUI
			default:  aluRes = '0;
		endcase
	end

	// Branch compare always on the raw register operands
	always_comb begin
		case (dec.brFunct3)
			brEq:    condMet = (rfRd1 == rfRd2);
			brNe:    condMet = (rfRd1 != rfRd2);
			brLt:    condMet = ($signed(rfRd1) < $signed(rfRd2));
			brGe:    condMet = ($signed(rfRd1) >= $signed(rfRd2));
			brLtu:   condMet = (rfRd1 < rfRd2);
			brGeu:   condMet = (rfRd1 >= rfRd2);
			default: condMet = 1'b0;
		endcase
	end

	assign pcRel = dec.pc + pcT'(dec.imm);

	always_comb begin
		exe.aluResult    = aluRes;
		exe.storeData    = rfRd2;
		exe.linkValue    = wordT'(dec.pc + pcT'(4));
		exe.redirect     = (dec.isBranch & condMet) | dec.isJal | dec.isJalr;
		exe.target       = dec.isJalr ? {aluRes[$bits(pcT)-1:1], 1'b0} : pcRel;
		exe.isLink       = dec.isJal | dec.isJalr;
		exe.isLoad       = dec.isLoad;
		exe.isStore      = dec.isStore;
		exe.regWrite     = dec.regWrite;
		exe.memSize      = dec.memSize;
		exe.loadUnsigned = dec.loadUnsigned;
		exe.rd           = dec.rd;
	end

	assign redirect = exe.redirect;
	assign target   = exe.target;

endmodule

`default_nettype wire

// File: rvMemAccess.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvCore_settings.svh"

module rvMemAccess (
	input  wire rvCorePkg::execT    exe,
	input  wire rvIsaPkg::wordT     dMemDi,
	output logic                    dMemCsn,
	output logic                    dMemWen,
	output logic [`RV_ADDR_W-3:0]   dMemAddr,
	output logic [3:0]              dMemBe,
	output rvIsaPkg::wordT          dMemDout,
	output logic                    rfWe,
	output rvIsaPkg::regIdxT        rfWa1,
	output rvIsaPkg::wordT          rfWd
);

	import rvIsaPkg::*;

	logic [1:0] byteOff;
	wordT       laneData; // Addressed bytes moved down to bit 0
	wordT       loadData;

	assign byteOff  = exe.aluResult[1:0];
	assign dMemAddr = exe.aluResult[`RV_ADDR_W-1:2];
	assign dMemCsn  = ~(exe.isLoad | exe.isStore);
	assign dMemWen  = ~exe.isStore;
	assign dMemDout = exe.storeData << {byteOff, 3'b000};
	assign laneData = dMemDi >> {byteOff, 3'b000};

	always_comb begin
		case (exe.memSize)
			memByte: dMemBe = 4'b0001 << byteOff;
			memHalf: dMemBe = 4'b0011 << {byteOff[1], 1'b0};
			default: dMemBe = 4'b1111;
		endcase
	end

	always_comb begin
		case (exe.memSize)
			memByte: loadData = {{24{~exe.loadUnsigned & laneData[7]}}, laneData[7:0]};
			memHalf: loadData = {{16{~exe.loadUnsigned & laneData[15]}}, laneData[15:0]};
			default: loadData = laneData;
		endcase
	end

	assign rfWe  = exe.regWrite;
	assign rfWa1 = exe.rd;
	assign rfWd  = exe.isLoad ? loadData : (exe.isLink ? exe.linkValue : exe.aluResult);

endmodule

`default_nettype wire

// File: rvTop.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvCore_settings.svh"

module rvTop (
	input  wire                       CLK,
	input  wire                       RSTn,

	output wire                       iMemCsn,
	input  wire rvIsaPkg::instrT      iMemDi,
	output wire rvIsaPkg::pcT         iMemAddr, // Byte address

	output wire                       dMemCsn,
	input  wire rvIsaPkg::wordT       dMemDi,
	output wire rvIsaPkg::wordT       dMemDout,
	output wire [`RV_ADDR_W-3:0]      dMemAddr, // Word address
	output wire                       dMemWen,
	output wire [3:0]                 dMemBe,

	output wire                       rfWe,
	output wire rvIsaPkg::regIdxT     rfRa1,
	output wire rvIsaPkg::regIdxT     rfRa2,
	output wire rvIsaPkg::regIdxT     rfWa1,
	input  wire rvIsaPkg::wordT       rfRd1,
	input  wire rvIsaPkg::wordT       rfRd2,
	output wire rvIsaPkg::wordT       rfWd,

	output wire                       halt,
	output wire rvIsaPkg::wordT       numInst
);

	import rvIsaPkg::*;
	import rvCorePkg::*;

	fetchT  fetch;
	decodeT dec;
	execT   exe;
	logic   redirect;
	pcT     target;

	rvFetch uFetch (
		.CLK(CLK), .RSTn(RSTn),
		.isHalt(dec.isHalt), .redirect(redirect), .target(target),
		.fetch(fetch),
		.iMemAddr(iMemAddr), .iMemCsn(iMemCsn), .iMemDi(iMemDi),
		.halt(halt), .numInst(numInst)
	);

	rvDecode uDecode (
		.fetch(fetch), .rfRa1(rfRa1), .rfRa2(rfRa2), .dec(dec)
	);

	rvExecute uExecute (
		.dec(dec), .rfRd1(rfRd1), .rfRd2(rfRd2),
		.exe(exe), .redirect(redirect), .target(target)
	);

	rvMemAccess uMemAccess (
		.exe(exe), .dMemDi(dMemDi),
		.dMemCsn(dMemCsn), .dMemWen(dMemWen), .dMemAddr(dMemAddr),
		.dMemBe(dMemBe), .dMemDout(dMemDout),
		.rfWe(rfWe), .rfWa1(rfWa1), .rfWd(rfWd)
	);

endmodule

`default_nettype wire

// File: rvTopTbModel.svh
`ifndef RV_TOP_TB_MODEL_SVH
`define RV_TOP_TB_MODEL_SVH

// Reference model state, stepped once per retired instruction
wordT       mRegs [0:31];
wordT       mMem [0:memWords-1];
pcT         mPc;
int         mCount;
logic       mHalted;

// Expected core outputs for the instruction just stepped
logic       expWe;
regIdxT     expWa;
wordT       expWd;
logic       expMemSel; // Load or store selects the data memory
logic       expStore;
wordT       expAddr;
logic [3:0] expBe;
wordT       expDout;

int         errCount = 0;
int         checkCount = 0;

task automatic checkWord(input string name, input wordT exp, input wordT act);
	checkCount++;
	if (act !== exp) begin
		errCount++;
		$display("FAIL %s: expected %08h, actual %08h", name, exp, act);
	end
endtask

task automatic checkPc(input string name, input pcT exp, input pcT act);
	checkCount++;
	if (act !== exp) begin
		errCount++;
		$display("FAIL %s: expected %03h, actual %03h", name, exp, act);
	end
endtask

task automatic checkFlag(input string name, input logic exp, input logic act);
	checkCount++;
	if (act !== exp) begin
		errCount++;
		$display("FAIL %s: expected %b, actual %b", name, exp, act);
	end
endtask

// RV32I integer op selected by funct3, alt is instruction bit 30
function automatic wordT aluModel(input logic [2:0] f3, input logic alt, input wordT a,
	input wordT b);
	case (f3)
		3'b000:  return alt ? a - b : a + b;
		3'b001:  return a << b[4:0];
		3'b010:  return wordT'($signed(a) < $signed(b));
		3'b011:  return wordT'(a < b);
		3'b100:  return a ^ b;
		3'b101:  return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'b110:  return a | b;
		default: return a & b;
	endcase
endfunction

task automatic modelReset();
	int i;
	for (i = 0; i < 32; i++)
		mRegs[i] = regInit[i];
	for (i = 0; i < memWords; i++)
		mMem[i] = dataInit[i];
	mPc     = pcT'(`RV_RESET_PC);
	mCount  = 0;
	mHalted = 1'b0;
endtask

task automatic modelStep();
	instrT      ins;
	logic [2:0] f3;
	wordT       a, b, immI, immS, immB, immJ, ea, lane;
	logic       taken;
	pcT         next;
	int         i;
	ins       = instrMem[mPc[`RV_ADDR_W-1:2]];
	f3        = ins[14:12];
	a         = mRegs[ins[19:15]];
	b         = mRegs[ins[24:20]];
	immI      = {{20{ins[31]}}, ins[31:20]};
	immS      = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	immB      = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
	immJ      = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
	next      = mPc + pcT'(4);
	expWe     = 1'b0;
	expWa     = ins[11:7];
	expWd     = '0;
	expMemSel = 1'b0;
	expStore  = 1'b0;
	case (ins[6:0])
		7'b0110111: begin // LUI
			expWe = 1'b1;
			expWd = {ins[31:12], 12'b0};
		end
		7'b0010111: begin
			expWe = 1'b1;
			expWd = wordT'(mPc) + {ins[31:12], 12'b0};
		end
		7'b1101111: begin // JAL
			expWe = 1'b1;
			expWd = wordT'(next);
			next  = mPc + pcT'(immJ);
		end
		7'b1100111: begin
			expWe = 1'b1;
			expWd = wordT'(next);
			ea    = a + immI;
			next  = pcT'({ea[31:1], 1'b0});
		end
		7'b1100011: begin
			case (f3)
				3'b000:  taken = (a == b);
				3'b001:  taken = (a != b);
				3'b100:  taken = ($signed(a) < $signed(b));
				3'b101:  taken = ($signed(a) >= $signed(b));
				3'b110:  taken = (a < b);
				default: taken = (a >= b);
			endcase
			if (taken)
				next = mPc + pcT'(immB);
		end
		7'b0000011: begin // Loads
			ea        = a + immI;
			lane      = mMem[ea[`RV_ADDR_W-1:2]] >> {ea[1:0], 3'b000};
			expWe     = 1'b1;
			expMemSel = 1'b1;
			case (f3)
				3'b000:  expWd = {{24{lane[7]}}, lane[7:0]};
				3'b001:  expWd = {{16{lane[15]}}, lane[15:0]};
				3'b100:  expWd = {24'b0, lane[7:0]};
				3'b101:  expWd = {16'b0, lane[15:0]};
				default: expWd = lane;
			endcase
		end
		7'b0100011: begin // Stores
			ea        = a + immS;
			expMemSel = 1'b1;
			expStore  = 1'b1;
			expAddr   = wordT'(ea[`RV_ADDR_W-1:2]);
			expDout   = b << {ea[1:0], 3'b000};
			case (f3)
				3'b000:  expBe = 4'b0001 << ea[1:0];
				3'b001:  expBe = 4'b0011 << ea[1:0];
				default: expBe = 4'b1111;
			endcase
			for (i = 0; i < 4; i++)
				if (expBe[i])
					mMem[ea[`RV_ADDR_W-1:2]][8*i +: 8] = expDout[8*i +: 8];
		end
		7'b0010011: begin
			expWe = 1'b1;
			expWd = aluModel(f3, (f3 == 3'b101) && ins[30], a, immI);
		end
		7'b0110011: begin
			expWe = 1'b1;
			expWd = aluModel(f3, ins[30], a, b);
		end
		7'b1110011: mHalted = 1'b1; // ECALL
		default: ;
	endcase
	if (expWe && expWa != 5'd0)
		mRegs[expWa] = expWd;
	mPc = next;
	mCount++;
endtask

`endif

// File: rvTopTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvCore_settings.svh"

module rvTopTb;

	import rvIsaPkg::*;

	localparam int memWords = 1 << (`RV_ADDR_W - 2);
	localparam int numProgs = 5;

	logic                  CLK = 1'b0;
	logic                  RSTn;
	logic                  iMemCsn;
	instrT                 iMemDi;
	pcT                    iMemAddr;
	logic                  dMemCsn;
	wordT                  dMemDi;
	wordT                  dMemDout;
	logic [`RV_ADDR_W-3:0] dMemAddr;
	logic                  dMemWen;
	logic [3:0]            dMemBe;
	logic                  rfWe;
	regIdxT                rfRa1, rfRa2, rfWa1;
	wordT                  rfRd1, rfRd2, rfWd;
	logic                  halt;
	wordT                  numInst;

	instrT instrMem [0:memWords-1];
	wordT  dataMem [0:memWords-1];
	wordT  regFile [0:31];
	wordT  dataInit [0:memWords-1]; // Staging copies for a new program
	wordT  regInit [0:31];
	logic  loadNow;
	int    failedProgs = 0;

	`include "rvTopTbModel.svh"

	always #20 CLK = ~CLK;

	rvTop UUT (
		.CLK(CLK), .RSTn(RSTn),
		.iMemCsn(iMemCsn), .iMemDi(iMemDi), .iMemAddr(iMemAddr),
		.dMemCsn(dMemCsn), .dMemDi(dMemDi), .dMemDout(dMemDout),
		.dMemAddr(dMemAddr), .dMemWen(dMemWen), .dMemBe(dMemBe),
		.rfWe(rfWe), .rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa1(rfWa1),
		.rfRd1(rfRd1), .rfRd2(rfRd2), .rfWd(rfWd),
		.halt(halt), .numInst(numInst)
	);

	// Memories and register file answer in the same cycle
	assign iMemDi = instrMem[iMemAddr[`RV_ADDR_W-1:2]];
	assign dMemDi = dataMem[dMemAddr];
	assign rfRd1  = regFile[rfRa1];
	assign rfRd2  = regFile[rfRa2];

	always @(posedge CLK) begin
		if (loadNow) begin
			regFile <= regInit;
			dataMem <= dataInit;
		end else begin
			if (rfWe && rfWa1 != 5'd0)
				regFile[rfWa1] <= rfWd;
			if (!dMemCsn && !dMemWen) begin
				for (int b = 0; b < 4; b++)
					if (dMemBe[b])
						dataMem[dMemAddr][8*b +: 8] <= dMemDout[8*b +: 8];
			end
		end
	end

	function automatic regIdxT randReg();
		return regIdxT'($urandom);
	endfunction

	function automatic logic [11:0] dataOffset(input logic [1:0] size);
		logic [7:0] off;
		off = 8'($urandom);
		if (size == 2'b10)
			off[1:0] = 2'b00;
		else if (size == 2'b01)
			off[0] = 1'b0;
		return {4'b0000, off};
	endfunction

	function automatic instrT encodeR(input logic [6:0] f7, input regIdxT rs2, input regIdxT rs1,
		input logic [2:0] f3, input regIdxT rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic instrT encodeI(input logic [11:0] imm, input regIdxT rs1,
		input logic [2:0] f3, input regIdxT rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic instrT encodeS(input logic [11:0] imm, input regIdxT rs2, input regIdxT rs1,
		input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic instrT encodeB(input logic [12:0] off, input regIdxT rs2, input regIdxT rs1,
		input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic instrT encodeJ(input logic [20:0] off, input regIdxT rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// x30 is kept for JALR targets and x31 holds the data base address
	task automatic genProgram(output int n);
		int          i, w, k, kind, lim, reach;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		regIdxT      rd;
		n = 40 + int'($urandom_range(40));
		for (w = 0; w < memWords; w++) begin
			instrMem[w] = encodeI(w[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011); // ADDI x0 fill
			dataInit[w] = $urandom;
		end
		for (w = 0; w < 32; w++)
			regInit[w] = $urandom;
		regInit[0]  = '0;
		regInit[31] = 32'h0000_0400;
		i     = 0;
		reach = 0; // Furthest forward target so far
		while (i < n) begin
			kind = int'($urandom_range(9));
			// No jump may land between the LUI and the JALR of a pair
			if (kind == 9 && (i + 3 > n || reach > i))
				kind = 0;
			rd  = regIdxT'($urandom_range(29));
			f3  = 3'($urandom);
			imm = 12'($urandom);
			f7  = (($urandom_range(1) == 1) && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
			lim = (n - i < 4) ? n - i : 4;
			k   = int'($urandom_range(lim, 1));
			case (kind)
				0, 1: instrMem[i] = encodeR(f7, randReg(), randReg(), f3, rd);
				2, 3: begin
					if (f3 == 3'b001)
						imm = {7'h00, imm[4:0]};
					else if (f3 == 3'b101)
						imm = {f7, imm[4:0]};
					instrMem[i] = encodeI(imm, randReg(), f3, rd, 7'b0010011);
				end
				4: instrMem[i] = {20'($urandom), rd,
					($urandom_range(1) == 1) ? 7'b0110111 : 7'b0010111};
				5: begin
					if (f3 == 3'b011 || f3[2:1] == 2'b11)
						f3 = 3'b010;
					instrMem[i] = encodeI(dataOffset(f3[1:0]), 5'd31, f3, rd, 7'b0000011);
				end
				6: begin
					f3 = {1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0]};
					instrMem[i] = encodeS(dataOffset(f3[1:0]), randReg(), 5'd31, f3);
				end
				7: begin
					if (f3[2:1] == 2'b01)
						f3[2] = 1'b1; // No branch on 010/011
					instrMem[i] = encodeB(13'(4 * k), randReg(), randReg(), f3);
					reach = (i + k > reach) ? i + k : reach;
				end
				8: begin
					instrMem[i] = encodeJ(21'(4 * k), rd);
					reach = (i + k > reach) ? i + k : reach;
				end
				default: begin // LUI/ADDI pair, then JALR through x30
					lim = (n - i - 2 < 4) ? n - i - 2 : 4;
					k   = int'($urandom_range(lim, 1));
					instrMem[i]     = {20'd0, 5'd30, 7'b0110111};
					instrMem[i + 1] = encodeI(12'(4 * (i + 2 + k)), 5'd30, 3'b000, 5'd30,
						7'b0010011);
					instrMem[i + 2] = encodeI(12'd0, 5'd30, 3'b000, rd, 7'b1100111);
					reach = i + 2 + k;
					i += 2;
				end
			endcase
			i++;
		end
		instrMem[n] = 32'h0000_0073; // ECALL
	endtask

	task automatic checkReset(input int prog);
		string tag;
		tag = $sformatf("prog%0d reset", prog);
		checkFlag({tag, " rfWe"}, 1'b0, rfWe);
		checkFlag({tag, " iMemCsn"}, 1'b1, iMemCsn);
		checkFlag({tag, " dMemCsn"}, 1'b1, dMemCsn);
		checkFlag({tag, " dMemWen"}, 1'b1, dMemWen);
		checkFlag({tag, " halt"}, 1'b0, halt);
		checkWord({tag, " numInst"}, '0, numInst);
	endtask

	task automatic checkCycle(input int prog);
		pcT    pc;
		string tag;
		pc  = mPc;
		tag = $sformatf("prog%0d pc %03h", prog, pc);
		modelStep();
		checkPc({tag, " iMemAddr"}, pc, iMemAddr);
		checkFlag({tag, " rfWe"}, expWe, rfWe);
		if (expWe) begin
			checkWord({tag, " rfWa1"}, wordT'(expWa), wordT'(rfWa1));
			checkWord({tag, " rfWd"}, expWd, rfWd);
		end
		checkFlag({tag, " dMemCsn"}, ~expMemSel, dMemCsn);
		checkFlag({tag, " dMemWen"}, ~expStore, dMemWen);
		if (expStore) begin
			checkWord({tag, " dMemAddr"}, expAddr, wordT'(dMemAddr));
			checkWord({tag, " dMemBe"}, wordT'(expBe), wordT'(dMemBe));
			checkWord({tag, " dMemDout"}, expDout, dMemDout);
		end
	endtask

	task automatic runProgram(input int prog);
		int    n, cycles, startErrs, i;
		string tag;
		startErrs = errCount;
		tag       = $sformatf("prog%0d", prog);
		@(posedge CLK);
		#1;
		RSTn = 1'b1;
		genProgram(n);
		loadNow = 1'b1;
		@(posedge CLK);
		#1;
		loadNow = 1'b0;
		modelReset();
		@(posedge CLK);
		@(negedge CLK);
		checkReset(prog);
		@(posedge CLK);
		#1;
		RSTn   = 1'b0;
		cycles = 0;
		while (!halt && !mHalted && cycles < 2 * n + 20) begin
			@(negedge CLK);
			if (!halt && !iMemCsn)
				checkCycle(prog);
			cycles++;
		end
		if (!halt && !mHalted) begin
			$display("program %0d: halt did not rise within %0d cycles", prog, cycles);
			errCount++;
		end else begin
			if (mHalted)
				@(negedge CLK); // Halt is due one edge after the ECALL cycle
			checkFlag({tag, " halt"}, mHalted, halt);
			checkWord({tag, " numInst"}, wordT'(mCount), numInst);
			repeat (10) begin
				@(negedge CLK);
				checkFlag({tag, " halted rfWe"}, 1'b0, rfWe);
				checkFlag({tag, " halted dMemWen"}, 1'b1, dMemWen);
				checkPc({tag, " halted iMemAddr"}, mPc, iMemAddr);
			end
			for (i = 0; i < 32; i++)
				checkWord($sformatf("%s x%0d", tag, i), mRegs[i], regFile[i]);
			for (i = 0; i < memWords; i++)
				checkWord($sformatf("%s mem[%03h]", tag, i), mMem[i], dataMem[i]);
		end
		if (errCount != startErrs)
			failedProgs++;
		$display("program %0d finished: %0d instructions retired, %0d errors", prog, mCount,
			errCount - startErrs);
	endtask

	initial begin
		RSTn    = 1'b1;
		loadNow = 1'b0;
		void'($urandom(32'h4021be60));
		for (int p = 0; p < numProgs; p++)
			runProgram(p);
		$display("summary: %0d programs, %0d failed, %0d checks, %0d errors", numProgs,
			failedProgs, checkCount, errCount);
		if (errCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: rvTop.f
+incdir+.
rvIsaPkg.sv
rvCorePkg.sv
rvFetch.sv
rvDecode.sv
rvExecute.sv
rvMemAccess.sv
rvTop.sv
rvTopTb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the rvTop testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=rvTopTbSim

if ! verilator --binary --timing --timescale 1ns/10ps \
	-f rvTop.f --top-module rvTopTb -o "$BIN"; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without a failure"
exit 0
